/* build.f */
logic/retire_pkg.sv
logic/reorder_buffer.sv
logic/mispredict_scan.sv
logic/rename_map.sv
logic/arch_regfile.sv
logic/ooo_retire_top.sv
tests/tb_ooo_retire.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the retirement slice testbench with Verilator, run it, check the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_ooo_retire -o sim_ooo_retire
./obj_dir/sim_ooo_retire | tee sim.log

if grep -qx "test passed" sim.log; then
    exit 0
else
    exit 1
fi

/* tests/retire_stimulus.txt */
# in:  test mask | d0 flags pc npc dst s0 s1 | d1 same | r0 flags tag value target | r1 same | grant
# out: op_ready op0 op1 op2 op3 | tag0 tag1 | status sq_tgt er_tgt | c0 flags dst value npc | c1 same
1 0 1 10 0 1 0 0 1 14 0 2 1 0 0 0 0 0 0 0 0 0 0 b 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
1 0 1 18 0 3 1 2 1 1c 0 4 3 0 1 1 22 0 0 0 0 0 0 8 0 1 2 0 2 3 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 3 44 0 1 2 33 0 0 f 0 0 0 0 4 5 0 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 11 0 0 0 0 0 0 f 0 0 0 0 4 5 0 0 0 0 0 0 0 0 0 0 0
2 0 1 20 0 5 1 3 1 24 0 6 5 4 0 0 0 0 0 0 0 0 0 b 11 33 4 44 4 5 0 0 0 3 1 11 14 3 2 22 18
2 0 1 28 0 7 2 0 1 2c 0 0 5 1 0 0 0 0 0 0 0 0 0 b 22 0 4 11 6 7 0 0 0 3 3 33 1c 3 4 44 20
3 0 1 30 0 8 0 0 1 34 0 9 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
3 0 1 38 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 2 3 0 0 0 0 0 0 0 0 0 0 0
3 0 3 3c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 3 4 2 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 1 4 55 0 1 5 66 0 0 f 0 0 0 0 4 5 3 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 4 5 3 0 0 3 5 55 24 3 6 66 28
3 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 77 0 1 7 88 0 0 f 0 0 0 0 4 5 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 aa 0 1 1 bb 0 0 f 0 0 0 0 4 5 0 0 0 3 7 77 2c 2 0 88 30
3 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 cc 0 1 3 dd 0 0 f 0 0 0 0 4 5 0 0 0 3 8 aa 34 3 9 bb 38
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 4 5 0 0 0 2 0 cc 3c 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 4 5 4 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 4 5 4 0 0 0 0 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 f 0 0 0 0 4 5 4 0 0 2 0 dd 40 0 0 0 0
5 0 1 50 0 a 0 0 d 54 58 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 4 5 0 0 0 0 0 0 0 0 0 0 0
5 0 1 60 0 b a 0 0 0 0 0 0 0 1 5 0 80 0 0 0 0 0 e 4 0 0 0 6 7 0 0 0 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 1 4 5a 0 0 0 0 0 0 f 0 0 0 0 7 0 13 0 80 0 0 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 7 0 1b 80 80 3 a 5a 54 2 0 0 58
5 0 1 80 0 c a b 11 84 0 0 c 0 0 0 0 0 0 0 0 0 0 b 5a 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0
6 0 1 88 0 d 0 0 0 0 0 0 0 0 1 0 12 0 1 1 0 0 0 f 0 0 0 0 2 3 0 0 0 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 13 0 0 0 0 0 0 f 0 0 0 0 3 4 0 0 0 3 c 12 84 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 3 4 20 0 0 2 0 0 88 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 f 0 0 0 0 3 4 0 0 0 3 d 13 8c 0 0 0 0

/* tests/tb_ooo_retire.sv */
// Testbench for the two-wide retirement slice.
// Replays per-cycle vectors from the stimulus file and checks every output group.

`timescale 1ns/1ps
`default_nettype none

module tb_ooo_retire;

    localparam int num_fields   = 41;
    localparam int reset_cycles = 3;

    logic clock;
    logic reset;
    logic store_grant;
    retire_pkg::dispatch_packet             dispatch_0, dispatch_1;
    retire_pkg::result_packet               result_0, result_1;
    retire_pkg::operand_packet [1:0]        operand_0, operand_1;
    logic [retire_pkg::tag_len-1:0]         dispatch_tag_0, dispatch_tag_1;
    logic                                   full_0, full_1, store_retire, halt;
    retire_pkg::commit_packet               commit_0, commit_1;
    retire_pkg::redirect_packet             squash_redirect, early_redirect;

    logic [31:0] fields [$];
    int num_lines = 0;
    int group_errors = 0;
    int total_errors = 0;
    int groups_passed = 0;
    int groups_failed = 0;
    bit loaded = 1'b0;

    ooo_retire_top #(.rob_size(8)) dut0 (
        .clock, .reset, .dispatch_0, .dispatch_1, .result_0, .result_1, .store_grant,
        .operand_0, .operand_1, .dispatch_tag_0, .dispatch_tag_1, .full_0, .full_1,
        .commit_0, .commit_1, .store_retire, .squash_redirect, .early_redirect, .halt
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // stimulus file
    ////////////////////////////////////////////////////////////

    // splits one text line into hex tokens
    task automatic parse_line(input string s);
        logic [31:0] v;
        logic [31:0] row [$];
        bit in_tok;
        byte c;
        v = '0;
        in_tok = 1'b0;
        if (s.len() > 0 && s[0] == "#") return;
        for (int i = 0; i <= s.len(); i++) begin
            c = (i < s.len()) ? s[i] : 8'h20;
            if (c >= "0" && c <= "9") begin
                v = {v[27:0], 4'(c - 8'h30)};
                in_tok = 1'b1;
            end else if (c >= "a" && c <= "f") begin
                v = {v[27:0], 4'(c - 8'h57)};
                in_tok = 1'b1;
            end else if (in_tok) begin
                row.push_back(v);
                v = '0;
                in_tok = 1'b0;
            end
        end
        if (row.size() == num_fields) begin
            foreach (row[k]) fields.push_back(row[k]);
            num_lines++;
        end else if (row.size() != 0) begin
            $display("stimulus line with %0d fields instead of %0d", row.size(), num_fields);
            total_errors++;
        end
    endtask

    task automatic load_stimulus();
        int fd;
        string s;
        fd = $fopen("tests/retire_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            total_errors++;
            return;
        end
        while ($fgets(s, fd) != 0) begin
            parse_line(s);
        end
        $fclose(fd);
    endtask

    task automatic fill_dispatch(input int b, output retire_pkg::dispatch_packet d);
        d             = '0;
        d.valid       = fields[b][0];
        d.is_store    = fields[b][1];
        d.is_branch   = fields[b][2];
        d.take_branch = fields[b][3];
        d.halt        = fields[b][4];
        d.pc          = fields[b+1];
        d.npc         = fields[b+2];
        d.dest_reg    = fields[b+3][4:0];
        d.src_reg[0]  = fields[b+4][4:0];
        d.src_reg[1]  = fields[b+5][4:0];
    endtask

    task automatic fill_result(input int b, output retire_pkg::result_packet r);
        r               = '0;
        r.valid         = fields[b][0];
        r.take_branch   = fields[b][1];
        r.tag           = fields[b+1][3:0];
        r.value         = fields[b+2];
        r.branch_target = fields[b+3];
    endtask

    task automatic drive_line(input int n);
        int b;
        b = n * num_fields;
        fill_dispatch(b + 2, dispatch_0);
        fill_dispatch(b + 8, dispatch_1);
        fill_result(b + 14, result_0);
        fill_result(b + 18, result_1);
        store_grant = fields[b+22][0];
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic compare(input int n, input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] line %0d %s expected %h actual %h", n + 1, name, expected, actual);
            group_errors++;
        end
    endtask

    task automatic check_commit(input int n, input string name, input int b,
                                input retire_pkg::commit_packet c);
        compare(n, {name, ".valid/dest_valid"}, fields[b][1:0], {30'b0, c.valid, c.dest_valid});
        if (fields[b][1]) begin
            compare(n, {name, ".dest_reg"}, fields[b+1], {27'b0, c.dest_reg});
            compare(n, {name, ".value"}, fields[b+2], c.value);
            compare(n, {name, ".next_pc"}, fields[b+3], c.next_pc);
        end
    endtask

    task automatic check_line(input int n);
        int b;
        logic [31:0] mask;
        logic [31:0] status;
        retire_pkg::operand_packet [3:0] ops;
        b = n * num_fields;
        mask = fields[b+1];
        ops = {operand_1, operand_0};
        status = {26'b0, halt, early_redirect.valid, squash_redirect.valid, store_retire,
                  full_1, full_0};
        if (!mask[0]) begin
            for (int i = 0; i < 4; i++) begin
                compare(n, $sformatf("operand_%0d[%0d].ready", i / 2, i % 2),
                        {31'b0, fields[b+23][i]}, {31'b0, ops[i].ready});
                if (fields[b+23][i])
                    compare(n, $sformatf("operand_%0d[%0d].value", i / 2, i % 2),
                            fields[b+24+i], ops[i].value);
                else
                    compare(n, $sformatf("operand_%0d[%0d].tag", i / 2, i % 2),
                            fields[b+24+i], {28'b0, ops[i].tag});
            end
        end
        if (!mask[1]) begin
            compare(n, "dispatch_tag_0", fields[b+28], {28'b0, dispatch_tag_0});
            compare(n, "dispatch_tag_1", fields[b+29], {28'b0, dispatch_tag_1});
        end
        if (!mask[2]) compare(n, "status", fields[b+30], status);
        if (!mask[3] && fields[b+30][3])
            compare(n, "squash_redirect.target", fields[b+31], squash_redirect.target);
        if (!mask[3] && fields[b+30][4])
            compare(n, "early_redirect.target", fields[b+32], early_redirect.target);
        if (!mask[4]) check_commit(n, "commit_0", b + 33, commit_0);
        if (!mask[5]) check_commit(n, "commit_1", b + 37, commit_1);
    endtask

    task automatic close_group(input logic [31:0] test_num);
        $display("group %0d: %0d mismatches", test_num, group_errors);
        if (group_errors == 0) groups_passed++;
        else groups_failed++;
        total_errors += group_errors;
        group_errors = 0;
    endtask

    // watchdog sized from the number of stimulus lines
    initial begin
        wait (loaded);
        #((num_lines + reset_cycles + 10) * 4);
        $display("watchdog expired before the last stimulus line was checked");
        $display("test failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        store_grant = 1'b0;
        dispatch_0 = '0;
        dispatch_1 = '0;
        result_0 = '0;
        result_1 = '0;
        load_stimulus();
        if (num_lines == 0) begin
            $display("no stimulus lines were read");
            total_errors++;
        end
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int n = 0; n < num_lines; n++) begin
            drive_line(n);
            #1.5;
            check_line(n);
            if (n == num_lines - 1 || fields[(n+1)*num_fields] != fields[n*num_fields])
                close_group(fields[n*num_fields]);
            @(negedge clock);
        end
        $display("groups passed %0d, groups failed %0d", groups_passed, groups_failed);
        if (total_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/ooo_retire_top.sv */
// Two-wide retirement slice.
// Reorder buffer, rename map, register file and early mispredict search.

`timescale 1ns/1ps
`default_nettype none

module ooo_retire_top #(
    parameter int rob_size = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  retire_pkg::dispatch_packet         dispatch_0,
    input  retire_pkg::dispatch_packet         dispatch_1,
    input  retire_pkg::result_packet           result_0,
    input  retire_pkg::result_packet           result_1,
    input  logic                               store_grant,
    output retire_pkg::operand_packet [1:0]    operand_0,
    output retire_pkg::operand_packet [1:0]    operand_1,
    output logic [retire_pkg::tag_len-1:0]     dispatch_tag_0,
    output logic [retire_pkg::tag_len-1:0]     dispatch_tag_1,
    output logic                               full_0,
    output logic                               full_1,
    output retire_pkg::commit_packet           commit_0,
    output retire_pkg::commit_packet           commit_1,
    output logic                               store_retire,
    output retire_pkg::redirect_packet         squash_redirect,
    output retire_pkg::redirect_packet         early_redirect,
    output logic                               halt
);

    retire_pkg::source_lookup [3:0]             lookup;
    retire_pkg::operand_packet [3:0]            operand;
    retire_pkg::rob_entry [rob_size-1:0]        entries;
    logic [3:0][retire_pkg::xlen-1:0]           reg_value;
    logic [retire_pkg::tag_len-1:0]             head;
    logic [retire_pkg::tag_len-1:0]             head_1;
    logic [retire_pkg::tag_len-1:0]             tail;
    logic [retire_pkg::tag_len:0]               count;

    // sources 0 and 1 belong to slot 0, 2 and 3 to slot 1
    assign operand_0 = operand[1:0];
    assign operand_1 = operand[3:2];

    reorder_buffer #(
        .rob_size(rob_size)
    ) rob0 (
        .clock, .reset,
        .dispatch_0, .dispatch_1,
        .result_0, .result_1,
        .store_grant, .early_redirect,
        .lookup, .reg_value, .operand,
        .tail_tag_0(dispatch_tag_0),
        .tail_tag_1(dispatch_tag_1),
        .full_0, .full_1, .halt, .store_retire,
        .commit_0, .commit_1, .squash_redirect,
        .entries, .head, .head_1, .tail, .count
    );

    mispredict_scan #(
        .rob_size(rob_size)
    ) scan0 (
        .entries, .head, .tail, .count, .early_redirect
    );

    rename_map map0 (
        .clock, .reset,
        .dispatch_0, .dispatch_1,
        .tail_tag_0(dispatch_tag_0),
        .tail_tag_1(dispatch_tag_1),
        .commit_0, .commit_1,
        .retire_tag_0(head),
        .retire_tag_1(head_1),
        .squash(squash_redirect.valid),
        .lookup
    );

    arch_regfile regs0 (
        .clock, .reset,
        .commit_0, .commit_1,
        .src_reg({dispatch_1.src_reg, dispatch_0.src_reg}),
        .reg_value
    );

endmodule

`default_nettype wire

/* logic/arch_regfile.sv */
// Architectural register file.
// Two retire write ports, four read ports, register 0 reads as zero.

`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  logic                                     clock,
    input  logic                                     reset,
    input  retire_pkg::commit_packet                 commit_0,
    input  retire_pkg::commit_packet                 commit_1,
    input  logic [3:0][retire_pkg::reg_idx_len-1:0]  src_reg,
    output logic [3:0][retire_pkg::xlen-1:0]         reg_value
);

    localparam int num_regs = 2 ** retire_pkg::reg_idx_len;

    logic [num_regs-1:0][retire_pkg::xlen-1:0] regs;

    // port 1 is younger, so it wins on a shared dest
    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '0;
        end else begin
            if (commit_0.dest_valid) begin
                regs[commit_0.dest_reg] <= commit_0.value;
            end
            if (commit_1.dest_valid) begin
                regs[commit_1.dest_reg] <= commit_1.value;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            reg_value[i] = (src_reg[i] == retire_pkg::zero_reg) ? '0 : regs[src_reg[i]];
        end
    end

endmodule

`default_nettype wire

/* logic/rename_map.sv */
// Rename map from architectural registers to reorder buffer tags.
// Set at dispatch, cleared by the matching retire, flushed on squash.

`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  logic                               clock,
    input  logic                               reset,
    input  retire_pkg::dispatch_packet         dispatch_0,
    input  retire_pkg::dispatch_packet         dispatch_1,
    input  logic [retire_pkg::tag_len-1:0]     tail_tag_0,
    input  logic [retire_pkg::tag_len-1:0]     tail_tag_1,
    input  retire_pkg::commit_packet           commit_0,
    input  retire_pkg::commit_packet           commit_1,
    input  logic [retire_pkg::tag_len-1:0]     retire_tag_0,
    input  logic [retire_pkg::tag_len-1:0]     retire_tag_1,
    input  logic                               squash,
    output retire_pkg::source_lookup [3:0]     lookup
);

    localparam int num_regs = 2 ** retire_pkg::reg_idx_len;

    logic [num_regs-1:0]                          pending;
    logic [num_regs-1:0][retire_pkg::tag_len-1:0] tags;
    logic write_0, write_1;

    assign write_0 = dispatch_0.valid && (dispatch_0.dest_reg != retire_pkg::zero_reg);
    assign write_1 = dispatch_0.valid && dispatch_1.valid
                     && (dispatch_1.dest_reg != retire_pkg::zero_reg);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup[i].pending = pending[dispatch_0.src_reg[i]];
            lookup[i].tag     = tags[dispatch_0.src_reg[i]];
            // slot 1 reads slot 0's result inside the same bundle
            if (write_0 && dispatch_1.src_reg[i] == dispatch_0.dest_reg) begin
                lookup[i+2].pending = 1'b1;
                lookup[i+2].tag     = tail_tag_0;
            end else begin
                lookup[i+2].pending = pending[dispatch_1.src_reg[i]];
                lookup[i+2].tag     = tags[dispatch_1.src_reg[i]];
            end
        end
    end

    // later assignments win, so a new dispatch beats a retire clear
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            pending <= '0;
        end else begin
            if (commit_0.dest_valid && tags[commit_0.dest_reg] == retire_tag_0) begin
                pending[commit_0.dest_reg] <= 1'b0;
            end
            if (commit_1.dest_valid && tags[commit_1.dest_reg] == retire_tag_1) begin
                pending[commit_1.dest_reg] <= 1'b0;
            end
            if (write_0) begin
                pending[dispatch_0.dest_reg] <= 1'b1;
                tags[dispatch_0.dest_reg]    <= tail_tag_0;
            end
            if (write_1) begin
                pending[dispatch_1.dest_reg] <= 1'b1;
                tags[dispatch_1.dest_reg]    <= tail_tag_1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/mispredict_scan.sv */
// Early redirect search.
// Finds the oldest completed mispredict in the live window
// and reports its branch target before it reaches the head.

`timescale 1ns/1ps
`default_nettype none

module mispredict_scan #(
    parameter int rob_size = 8
) (
    input  retire_pkg::rob_entry [rob_size-1:0]  entries,
    input  logic [retire_pkg::tag_len-1:0]       head,
    input  logic [retire_pkg::tag_len-1:0]       tail,
    input  logic [retire_pkg::tag_len:0]         count,
    output retire_pkg::redirect_packet           early_redirect
);

    localparam logic [retire_pkg::tag_len:0] full_count = (retire_pkg::tag_len + 1)'(rob_size);

    always_comb begin
        int   idx;
        logic live;
        early_redirect = '0;
        // walk from head so the first hit is the oldest
        for (int k = 0; k < rob_size; k++) begin
            idx  = (int'(head) + k) % rob_size;
            // head equals tail both when empty and when full
            live = (count == full_count) ||
                   ((head <= tail) ? (idx >= int'(head) && idx < int'(tail))
                                   : (idx >= int'(head) || idx < int'(tail)));
            if (live && !early_redirect.valid && entries[idx].ready && entries[idx].mis_pred) begin
                early_redirect.valid  = 1'b1;
                early_redirect.target = entries[idx].branch_target;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/reorder_buffer.sv */
// Reorder buffer for a two-wide machine.
// Dispatches two entries at the tail, marks completions by tag,
// retires up to two in order from the head and flushes on mispredict.
// Also resolves the four dispatch source operands.

`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_size = 8
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  retire_pkg::dispatch_packet                  dispatch_0,
    input  retire_pkg::dispatch_packet                  dispatch_1,
    input  retire_pkg::result_packet                    result_0,
    input  retire_pkg::result_packet                    result_1,
    input  logic                                        store_grant,
    input  retire_pkg::redirect_packet                  early_redirect,
    input  retire_pkg::source_lookup [3:0]              lookup,
    input  logic [3:0][retire_pkg::xlen-1:0]            reg_value,
    output retire_pkg::operand_packet [3:0]             operand,
    output logic [retire_pkg::tag_len-1:0]              tail_tag_0,
    output logic [retire_pkg::tag_len-1:0]              tail_tag_1,
    output logic                                        full_0,
    output logic                                        full_1,
    output logic                                        halt,
    output logic                                        store_retire,
    output retire_pkg::commit_packet                    commit_0,
    output retire_pkg::commit_packet                    commit_1,
    output retire_pkg::redirect_packet                  squash_redirect,
    output retire_pkg::rob_entry [rob_size-1:0]         entries,
    output logic [retire_pkg::tag_len-1:0]              head,
    output logic [retire_pkg::tag_len-1:0]              head_1,
    output logic [retire_pkg::tag_len-1:0]              tail,
    output logic [retire_pkg::tag_len:0]                count
);

    localparam logic [retire_pkg::tag_len:0] full_count = (retire_pkg::tag_len + 1)'(rob_size);

    logic [retire_pkg::tag_len-1:0]           next_head;
    logic [retire_pkg::tag_len-1:0]           next_tail;
    logic [retire_pkg::tag_len:0]             next_count;
    retire_pkg::rob_entry [rob_size-1:0]      next_entries;
    retire_pkg::rob_entry                     first;
    retire_pkg::rob_entry                     second;
    retire_pkg::result_packet [1:0]           results;
    logic [3:0][retire_pkg::reg_idx_len-1:0]  src_reg;
    logic valid_0, valid_1;
    logic retire_0, retire_1;
    logic squash_0, squash_1;

    function automatic logic [retire_pkg::tag_len-1:0] step(
        input logic [retire_pkg::tag_len-1:0] t
    );
        return (t == retire_pkg::tag_len'(rob_size - 1)) ? '0 : t + 1'b1;
    endfunction

    function automatic retire_pkg::commit_packet make_commit(
        input retire_pkg::rob_entry e,
        input logic fire
    );
        retire_pkg::commit_packet c;
        c.valid      = fire;
        c.dest_valid = fire && (e.dest_reg != retire_pkg::zero_reg);
        c.dest_reg   = e.dest_reg;
        c.value      = e.value;
        c.next_pc    = e.pc + 32'd4;
        return c;
    endfunction

    function automatic retire_pkg::rob_entry new_entry(input retire_pkg::dispatch_packet d);
        retire_pkg::rob_entry e;
        e               = '0;
        e.valid         = 1'b1;
        e.pc            = d.pc;
        e.npc           = d.npc;
        e.dest_reg      = d.dest_reg;
        e.is_store      = d.is_store;
        e.is_branch     = d.is_branch;
        e.take_branch   = d.take_branch;
        e.halt          = d.halt;
        return e;
    endfunction

    assign head_1     = step(head);
    assign tail_tag_0 = tail;
    assign tail_tag_1 = step(tail);
    assign first      = entries[head];
    assign second     = entries[head_1];
    assign results    = {result_1, result_0};
    assign src_reg    = {dispatch_1.src_reg, dispatch_0.src_reg};

    assign valid_0 = dispatch_0.valid;
    assign valid_1 = dispatch_0.valid && dispatch_1.valid;

    // a completed mispredict anywhere stops dispatch until it retires
    assign full_0 = (count == full_count) || early_redirect.valid;
    assign full_1 = full_0 || (count == full_count - 1'b1);

    assign halt         = first.valid && first.ready && first.halt;
    assign store_retire = first.valid && first.ready && first.is_store;

    ////////////////////////////////////////////////////////////
    // retire and squash
    ////////////////////////////////////////////////////////////
    assign retire_0 = first.valid && first.ready && (!first.is_store || store_grant);
    assign squash_0 = retire_0 && first.mis_pred;
    assign retire_1 = retire_0 && !squash_0 && !first.halt && second.valid && second.ready
                      && !second.is_store && !second.halt;
    assign squash_1 = retire_1 && second.mis_pred;

    assign squash_redirect.valid  = squash_0 || squash_1;
    assign squash_redirect.target = squash_0 ? first.branch_target : second.branch_target;

    assign commit_0 = make_commit(first, retire_0);
    assign commit_1 = make_commit(second, retire_1);

    // operands see entry values only as of the last edge
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            operand[i].tag = lookup[i].tag;
            if (src_reg[i] == retire_pkg::zero_reg) begin
                operand[i].ready = 1'b1;
                operand[i].value = '0;
            end else if (!lookup[i].pending) begin
                operand[i].ready = 1'b1;
                operand[i].value = reg_value[i];
            end else if (entries[lookup[i].tag].valid && entries[lookup[i].tag].ready) begin
                operand[i].ready = 1'b1;
                operand[i].value = entries[lookup[i].tag].value;
            end else begin
                operand[i].ready = 1'b0;
                operand[i].value = '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////
    always_comb begin
        next_entries = entries;
        for (int r = 0; r < 2; r++) begin
            if (results[r].valid && entries[results[r].tag].valid) begin
                next_entries[results[r].tag].ready         = 1'b1;
                next_entries[results[r].tag].value         = results[r].value;
                next_entries[results[r].tag].branch_target = results[r].branch_target;
                // wrong direction, or a branch that went somewhere unpredicted
                next_entries[results[r].tag].mis_pred =
                    (entries[results[r].tag].take_branch != results[r].take_branch) ||
                    (entries[results[r].tag].is_branch &&
                     entries[results[r].tag].npc != results[r].branch_target);
            end
        end
        if (retire_0) begin
            next_entries[head].valid = 1'b0;
            next_entries[head].ready = 1'b0;
        end
        if (retire_1) begin
            next_entries[head_1].valid = 1'b0;
            next_entries[head_1].ready = 1'b0;
        end
        if (valid_0) begin
            next_entries[tail_tag_0] = new_entry(dispatch_0);
        end
        if (valid_1) begin
            next_entries[tail_tag_1] = new_entry(dispatch_1);
        end
        next_head  = retire_1 ? step(head_1) : (retire_0 ? head_1 : head);
        next_tail  = valid_1 ? step(tail_tag_1) : (valid_0 ? tail_tag_1 : tail);
        next_count = count + {4'b0, valid_0} + {4'b0, valid_1}
                     - {4'b0, retire_0} - {4'b0, retire_1};
    end

    always_ff @(posedge clock) begin
        if (reset || squash_redirect.valid) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            head    <= next_head;
            tail    <= next_tail;
            count   <= next_count;
            entries <= next_entries;
        end
    end

endmodule

`default_nettype wire

/* logic/retire_pkg.sv */
// Shared widths and packed records for the two-wide retirement slice.
// Used by every RTL block and by the testbench.

`default_nettype none

package retire_pkg;

    localparam int xlen = 32;
    localparam int reg_idx_len = 5;
    localparam logic [reg_idx_len-1:0] zero_reg = '0;
    // tag width bounds the buffer at 16 entries
    localparam int tag_len = 4;

    typedef struct packed {
        logic                             valid;
        logic [xlen-1:0]                  pc;
        logic [xlen-1:0]                  npc;
        logic [reg_idx_len-1:0]           dest_reg;
        logic [1:0][reg_idx_len-1:0]      src_reg;
        logic                             is_store;
        logic                             is_branch;
        logic                             take_branch;
        logic                             halt;
    } dispatch_packet;

    typedef struct packed {
        logic                valid;
        logic [tag_len-1:0]  tag;
        logic [xlen-1:0]     value;
        logic                take_branch;
        logic [xlen-1:0]     branch_target;
    } result_packet;

    typedef struct packed {
        logic                pending;
        logic [tag_len-1:0]  tag;
    } source_lookup;

    typedef struct packed {
        logic                ready;
        logic [tag_len-1:0]  tag;
        logic [xlen-1:0]     value;
    } operand_packet;

    typedef struct packed {
        logic                    valid;
        logic                    dest_valid;
        logic [reg_idx_len-1:0]  dest_reg;
        logic [xlen-1:0]         value;
        logic [xlen-1:0]         next_pc;
    } commit_packet;

    typedef struct packed {
        logic             valid;
        logic [xlen-1:0]  target;
    } redirect_packet;

    typedef struct packed {
        logic                    valid;
        logic                    ready;
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         npc;
        logic [reg_idx_len-1:0]  dest_reg;
        logic [xlen-1:0]         value;
        logic                    is_store;
        logic                    is_branch;
        logic                    take_branch;
        logic                    mis_pred;
        logic [xlen-1:0]         branch_target;
        logic                    halt;
    } rob_entry;

endpackage

`default_nettype wire
